//--- bit_plru.sv
`timescale 1ns/1ns

module bit_plru #(
    parameter int NUM_SETS = 2,
    parameter int NUM_WAYS = 8,
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                clock,
    input  logic                reset,
    input  logic [SET_BITS-1:0] set_index,
    input  logic                touch_en,
    input  logic [WAY_BITS-1:0] touch_way,
    input  logic [NUM_WAYS-1:0] way_valid,   // Valid bits of the addressed set
    output logic [WAY_BITS-1:0] replace_way
);

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] status_bits;  // One MRU bit per way
    logic [NUM_WAYS-1:0]               touched_bits; // Next value of the addressed set
    logic                              any_invalid;

    // Set the touched way, wrap to just that way once every bit is set
    always_comb begin
        touched_bits = status_bits[set_index];
        touched_bits[touch_way] = 1'b1;
        if (&touched_bits) begin
            touched_bits = '0;
            touched_bits[touch_way] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            status_bits <= '0;
        end else if (touch_en) begin
            status_bits[set_index] <= touched_bits;
        end
    end

    assign any_invalid = ~&way_valid;

    // Lowest empty way first, else lowest way not recently used
    always_comb begin
        replace_way = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (any_invalid ? !way_valid[i] : !status_bits[set_index][i]) begin
                replace_way = WAY_BITS'(i);  // Downward scan keeps the lowest
            end
        end
    end

endmodule

//--- cache_pkg.sv
package cache_pkg;

    // Only the low 64 KB of the address space selects data
    localparam int ADDR_BITS = 16;

    // 8-byte blocks
    localparam int OFFSET_BITS = 3;

    // Tag plus set index, everything above the byte offset
    localparam int BLOCK_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    // One cache block with several views of the same 64 bits
    typedef union packed {
        logic [63:0]      double;  // Whole block
        logic [1:0][31:0] words;   // Word 1 is the upper half
        logic [3:0][15:0] halves;
        logic [7:0][7:0]  bytes;   // Byte 0 at the lowest address
    } cache_block_t;

endpackage

//--- dcache.f
cache_pkg.sv
mem_bus_pkg.sv
bit_plru.sv
dcache_ways.sv
victim_cache.sv
miss_handler.sv
dcache.sv
dcache_tb.sv

//--- dcache.sv
`timescale 1ns/1ns

module dcache #(
    parameter int NUM_SETS       = 2,
    parameter int NUM_WAYS       = 8,
    parameter int VICTIM_ENTRIES = 2
) (
    input  logic                         clock,
    input  logic                         reset,

    // Processor side, address is a level
    input  logic [mem_bus_pkg::XLEN-1:0]  proc2Dcache_addr,
    output logic [mem_bus_pkg::XLEN-1:0]  Dcache2proc_data,
    output logic                         Dcache2proc_valid,

    // Memory side
    output mem_bus_pkg::bus_command_t    Dcache2mem_command,
    output logic [mem_bus_pkg::XLEN-1:0]  Dcache2mem_addr,
    input  mem_bus_pkg::mem_tag_t        mem2Dcache_response,
    input  logic [63:0]                  mem2Dcache_data,
    input  mem_bus_pkg::mem_tag_t        mem2Dcache_tag
);
    import cache_pkg::*;

    logic [BLOCK_ADDR_BITS-1:0] proc_block_addr;

    // Main arrays
    logic                       ways_hit;
    cache_block_t               ways_block;
    logic                       write_en;
    logic [BLOCK_ADDR_BITS-1:0] write_addr;
    cache_block_t               write_block;
    logic                       evict_valid;
    logic [BLOCK_ADDR_BITS-1:0] evict_addr;
    cache_block_t               evict_block;

    // Victim cache
    logic [BLOCK_ADDR_BITS-1:0] vc_lookup_addr;
    logic                       vc_hit;
    cache_block_t               vc_block;

    // Miss path
    logic                       miss_start;
    logic                       miss_busy;
    logic                       fill_en;
    logic [BLOCK_ADDR_BITS-1:0] fill_addr;
    cache_block_t               fill_block;

    // Swap state
    logic                       swap_q;       // Swap cycle in progress
    logic [BLOCK_ADDR_BITS-1:0] swap_addr_q;  // Block moving back from the victim cache
    logic                       swap_start;
    logic                       can_start;

    assign proc_block_addr = proc2Dcache_addr[ADDR_BITS-1:OFFSET_BITS];  // Upper bits ignored

    // New work only when nothing else touches the arrays
    assign can_start  = !swap_q && !miss_busy;
    assign swap_start = can_start && !ways_hit && vc_hit;
    assign miss_start = can_start && !ways_hit && !vc_hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            swap_q <= 1'b0;
        end else begin
            swap_q <= swap_start;  // One cycle only
        end
    end

    always_ff @(posedge clock) begin
        if (swap_start) swap_addr_q <= proc_block_addr;
    end

    // Swap and fill never overlap since a swap needs the miss path idle
    assign write_en    = swap_q | fill_en;
    assign write_addr  = swap_q ? swap_addr_q : fill_addr;
    assign write_block = swap_q ? vc_block : fill_block;

    // Keep looking at the swapped block through the swap cycle
    assign vc_lookup_addr = swap_q ? swap_addr_q : proc_block_addr;

    dcache_ways #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_dcache_ways (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (proc_block_addr),
        .hit         (ways_hit),
        .hit_block   (ways_block),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_block (write_block),
        .evict_valid (evict_valid),
        .evict_addr  (evict_addr),
        .evict_block (evict_block)
    );

    // Displaced block takes the freed victim slot on a swap
    victim_cache #(
        .VICTIM_ENTRIES (VICTIM_ENTRIES)
    ) u_victim_cache (
        .clock        (clock),
        .reset        (reset),
        .lookup_addr  (vc_lookup_addr),
        .hit          (vc_hit),
        .hit_block    (vc_block),
        .remove_en    (swap_q),
        .insert_en    (write_en && evict_valid),
        .insert_addr  (evict_addr),
        .insert_block (evict_block)
    );

    miss_handler u_miss_handler (
        .clock               (clock),
        .reset               (reset),
        .start               (miss_start),
        .block_addr          (proc_block_addr),
        .busy                (miss_busy),
        .fill_en             (fill_en),
        .fill_addr           (fill_addr),
        .fill_block          (fill_block),
        .Dcache2mem_command  (Dcache2mem_command),
        .Dcache2mem_addr     (Dcache2mem_addr),
        .mem2Dcache_response (mem2Dcache_response),
        .mem2Dcache_data     (mem2Dcache_data),
        .mem2Dcache_tag      (mem2Dcache_tag)
    );

    // Array hits only, swaps and fills show up as a hit one cycle later
    assign Dcache2proc_valid = ways_hit;
    assign Dcache2proc_data  = ways_block.words[proc2Dcache_addr[OFFSET_BITS-1]];  // Bit 2 picks word

endmodule

//--- dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
    import mem_bus_pkg::*;
    import cache_pkg::*;

    typedef enum {KIND_ARRAY, KIND_VICTIM, KIND_MISS} hit_kind_t;

    localparam int              SEED     = 80072;
    localparam logic [XLEN-1:0] DATA_KEY = 32'h5A5A_0000;  // Word at A is A ^ key

    logic              clock = 1'b0;
    logic              reset = 1'b1;
    logic [XLEN-1:0]   proc2Dcache_addr = '0;
    logic [XLEN-1:0]   Dcache2proc_data;
    logic              Dcache2proc_valid;
    bus_command_t      Dcache2mem_command;
    logic [XLEN-1:0]   Dcache2mem_addr;
    mem_tag_t          mem2Dcache_response = '0;
    logic [63:0]       mem2Dcache_data = '0;
    mem_tag_t          mem2Dcache_tag = '0;

    // Stimulus table, one entry per row in each queue
    string             row_name [$];
    logic [XLEN-1:0]   row_addr [$];
    int                row_loads [$];   // Accepted bus loads expected
    hit_kind_t         row_kind [$];

    string             cur_name = "reset";
    logic [XLEN-1:0]   cur_addr = '0;
    int                cycle_count = 0;
    int                timeout_cycles = 1000;

    // Memory model state
    int                accept_count = 0;
    int                refusal_cycles = 0;
    int                wrong_tags_sent = 0;
    bit                req_active = 1'b0;   // Load seen, not yet accepted
    int                refuse_left = 0;
    bit                ret_pending = 1'b0;  // Accepted, data not yet returned
    int                delay_left = 0;
    bit                wrong_first = 1'b0;
    mem_tag_t          next_tag = 4'h1;     // Rotates over 1 to 15
    mem_tag_t          ret_tag = 4'h0;
    logic [XLEN-1:0]   ret_addr = '0;

    dcache u_dcache (
        .clock               (clock),
        .reset               (reset),
        .proc2Dcache_addr    (proc2Dcache_addr),
        .Dcache2proc_data    (Dcache2proc_data),
        .Dcache2proc_valid   (Dcache2proc_valid),
        .Dcache2mem_command  (Dcache2mem_command),
        .Dcache2mem_addr     (Dcache2mem_addr),
        .mem2Dcache_response (mem2Dcache_response),
        .mem2Dcache_data     (mem2Dcache_data),
        .mem2Dcache_tag      (mem2Dcache_tag)
    );

    always #4 clock = ~clock;  // 8 ns period

    function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] addr);
        return {16'h0000, addr[15:2], 2'b00} ^ DATA_KEY;  // Upper 16 bits ignored
    endfunction

    function automatic logic [XLEN-1:0] block_base(input logic [XLEN-1:0] addr);
        return {16'h0000, addr[15:3], 3'b000};
    endfunction

    function automatic cache_block_t block_data(input logic [XLEN-1:0] base);
        cache_block_t blk;
        blk.words[0] = base ^ DATA_KEY;
        blk.words[1] = (base + 32'd4) ^ DATA_KEY;  // Upper word at base + 4
        return blk;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED %s: data expected %08h, actual %08h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_command(input string name, input bus_command_t expected,
                                 input bus_command_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED %s: command expected %s, actual %s",
                                     name, expected.name(), actual.name()));
        end
    endtask

    task automatic check_addr(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED %s: bus address expected %08h, actual %08h",
                                     name, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input logic [XLEN-1:0] addr, input int loads,
                           input hit_kind_t kind);
        row_name.push_back(name);
        row_addr.push_back(addr);
        row_loads.push_back(loads);
        row_kind.push_back(kind);
    endtask

    // Called at a falling edge, returns once valid is seen and checked
    task automatic run_row(input string name, input logic [XLEN-1:0] addr, input int loads,
                           input hit_kind_t kind);
        int loads_before;
        int cycles;
        loads_before     = accept_count;
        cur_name         = name;
        cur_addr         = addr;
        proc2Dcache_addr = addr;
        cycles           = 0;
        #2;  // Mid low phase, combinational outputs settled
        while (!Dcache2proc_valid) begin
            if (loads == 0) check_command(name, BUS_NONE, Dcache2mem_command);
            @(negedge clock);
            #2;
            cycles++;
        end
        check_data(name, expected_word(addr), Dcache2proc_data);
        if (ret_pending) begin
            report_failure($sformatf("Test %s saw valid before the matching tag returned", name));
        end
        if (accept_count - loads_before != loads) begin
            report_failure($sformatf("FAILED %s: bus loads expected %0d, actual %0d",
                                     name, loads, accept_count - loads_before));
        end
        case (kind)
            KIND_ARRAY: if (cycles != 0) begin
                report_failure($sformatf("FAILED %s: latency expected 0, actual %0d",
                                         name, cycles));
            end
            KIND_VICTIM: if (cycles < 1 || cycles > 2) begin
                report_failure($sformatf("FAILED %s: latency expected 1 to 2, actual %0d",
                                         name, cycles));
            end
            default: if (cycles == 0) begin
                report_failure($sformatf("FAILED %s: latency expected above 0, actual 0",
                                         name));
            end
        endcase
    endtask

    // Memory model, refuses 0 to 3 cycles, answers 1 to 6 cycles after accepting
    always @(negedge clock) begin
        mem2Dcache_response = '0;
        mem2Dcache_tag      = '0;
        mem2Dcache_data     = '0;
        if (Dcache2mem_command == BUS_LOAD) begin
            check_addr(cur_name, block_base(cur_addr), Dcache2mem_addr);  // Same every cycle
            if (!req_active) begin
                req_active  = 1'b1;
                refuse_left = int'($urandom_range(3, 0));
            end
            if (refuse_left == 0) begin
                mem2Dcache_response = next_tag;  // Accepted under this tag
                ret_tag     = next_tag;
                ret_addr    = Dcache2mem_addr;
                next_tag    = (next_tag == 4'hF) ? 4'h1 : next_tag + 4'h1;
                delay_left  = int'($urandom_range(6, 1));
                wrong_first = ($urandom_range(1, 0) == 1);
                req_active  = 1'b0;
                ret_pending = 1'b1;
                accept_count++;
            end else begin
                refuse_left--;
                refusal_cycles++;  // Back-pressure cycle
            end
        end else if (req_active) begin
            check_command(cur_name, BUS_LOAD, Dcache2mem_command);  // Dropped while refused
        end else if (ret_pending) begin
            if (delay_left > 1) begin
                delay_left--;
            end else if (wrong_first) begin
                mem2Dcache_tag  = (ret_tag == 4'hF) ? 4'h1 : ret_tag + 4'h1;  // Someone else's
                mem2Dcache_data = {$urandom, $urandom};
                wrong_first     = 1'b0;
                delay_left      = int'($urandom_range(2, 1));
                wrong_tags_sent++;
            end else begin
                mem2Dcache_tag  = ret_tag;
                mem2Dcache_data = block_data(ret_addr);
                ret_pending     = 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            report_failure($sformatf("Timeout after %0d cycles during test %s",
                                     cycle_count, cur_name));
        end
    end

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        add_row("cold_miss", 32'h0000_0020, 1, KIND_MISS);
        add_row("hit_word1", 32'h0000_0024, 0, KIND_ARRAY);
        add_row("hit_word0", 32'h0000_0020, 0, KIND_ARRAY);
        for (int k = 1; k <= 8; k++) begin  // Set 0 fills, the eighth evicts the first
            add_row($sformatf("fill_set0_%0d", k), k * 32'h1000 + 32'h20, 1, KIND_MISS);
        end
        add_row("victim_swap", 32'h0000_0020, 0, KIND_VICTIM);
        add_row("swapped_word1", 32'h0000_0024, 0, KIND_ARRAY);
        add_row("evict_second", 32'h0000_9020, 1, KIND_MISS);
        add_row("evict_third", 32'h0000_A020, 1, KIND_MISS);  // Oldest victim dropped
        add_row("dropped_refetch", 32'h0000_1020, 1, KIND_MISS);
        add_row("victim_kept", 32'h0000_3024, 0, KIND_VICTIM);
        add_row("upper_bits_ignored", 32'h0001_0024, 0, KIND_ARRAY);
        add_row("set1_miss", 32'h0000_0028, 1, KIND_MISS);
        add_row("set1_hit_word1", 32'h0000_002C, 0, KIND_ARRAY);
        timeout_cycles = 3 + 40 * row_name.size();
        repeat (3) @(posedge clock);
        for (int i = 0; i < row_name.size(); i++) begin
            @(negedge clock);
            reset = 1'b0;  // First address goes in as reset drops
            run_row(row_name[i], row_addr[i], row_loads[i], row_kind[i]);
        end
        if (refusal_cycles == 0) begin
            report_failure("Memory never refused a request, back-pressure untested");
        end else if (wrong_tags_sent == 0) begin
            report_failure("Memory never sent a wrong tag, tag matching untested");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- dcache_ways.sv
`timescale 1ns/1ns

module dcache_ways #(
    parameter int NUM_SETS = 2,
    parameter int NUM_WAYS = 8,
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int TAG_BITS = cache_pkg::BLOCK_ADDR_BITS - SET_BITS
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [cache_pkg::BLOCK_ADDR_BITS-1:0] lookup_addr,
    output logic                                 hit,
    output cache_pkg::cache_block_t              hit_block,
    input  logic                                 write_en,
    input  logic [cache_pkg::BLOCK_ADDR_BITS-1:0] write_addr,
    input  cache_pkg::cache_block_t              write_block,
    output logic                                 evict_valid,
    output logic [cache_pkg::BLOCK_ADDR_BITS-1:0] evict_addr,
    output cache_pkg::cache_block_t              evict_block
);
    import cache_pkg::*;

    logic [TAG_BITS-1:0]               tags [NUM_SETS][NUM_WAYS];
    cache_block_t                      data [NUM_SETS][NUM_WAYS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valids;

    logic [SET_BITS-1:0] lookup_set, write_set, plru_set;
    logic [TAG_BITS-1:0] lookup_tag, write_tag;
    logic [WAY_BITS-1:0] hit_way, touch_way, replace_way;

    // Block address is {tag, set}
    assign lookup_set = lookup_addr[SET_BITS-1:0];
    assign lookup_tag = lookup_addr[BLOCK_ADDR_BITS-1:SET_BITS];
    assign write_set  = write_addr[SET_BITS-1:0];
    assign write_tag  = write_addr[BLOCK_ADDR_BITS-1:SET_BITS];

    // Compare every way of the looked-up set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valids[lookup_set][w] && tags[lookup_set][w] == lookup_tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit_block = data[lookup_set][hit_way];

    // PLRU follows the lookup set only on a plain hit
    assign plru_set  = (hit && !write_en) ? lookup_set : write_set;
    assign touch_way = write_en ? replace_way : hit_way;

    bit_plru #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_bit_plru (
        .clock       (clock),
        .reset       (reset),
        .set_index   (plru_set),
        .touch_en    (hit | write_en),
        .touch_way   (touch_way),
        .way_valid   (valids[plru_set]),
        .replace_way (replace_way)
    );

    // Current occupant of the victim way, visible before the write edge
    assign evict_valid = valids[write_set][replace_way];
    assign evict_addr  = {tags[write_set][replace_way], write_set};
    assign evict_block = data[write_set][replace_way];

    always_ff @(posedge clock) begin
        if (reset) begin
            valids <= '0;
        end else if (write_en) begin
            valids[write_set][replace_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            tags[write_set][replace_way] <= write_tag;
            data[write_set][replace_way] <= write_block;  // Fill or swapped-in block
        end
    end

endmodule

//--- mem_bus_pkg.sv
package mem_bus_pkg;

    // Processor word width
    localparam int XLEN = 32;

    // Bus command encoding
    typedef enum logic [1:0] {
        BUS_NONE  = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10  // Encoding only, cache never stores
    } bus_command_t;

    // Transaction tag, zero means no response
    typedef logic [3:0] mem_tag_t;

endpackage

//--- miss_handler.sv
`timescale 1ns/1ns

module miss_handler (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic [cache_pkg::BLOCK_ADDR_BITS-1:0] block_addr,
    output logic                                 busy,
    output logic                                 fill_en,
    output logic [cache_pkg::BLOCK_ADDR_BITS-1:0] fill_addr,
    output cache_pkg::cache_block_t              fill_block,
    output mem_bus_pkg::bus_command_t            Dcache2mem_command,
    output logic [mem_bus_pkg::XLEN-1:0]          Dcache2mem_addr,
    input  mem_bus_pkg::mem_tag_t                mem2Dcache_response,
    input  logic [63:0]                          mem2Dcache_data,
    input  mem_bus_pkg::mem_tag_t                mem2Dcache_tag
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_REQ,   // BUS_LOAD on the bus until a nonzero response
        MISS_WAIT   // Accepted, waiting for our tag
    } miss_state_t;

    miss_state_t                state;
    logic [BLOCK_ADDR_BITS-1:0] addr_q;  // Block being fetched
    mem_tag_t                   tag_q;   // Tag handed out by memory

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= MISS_IDLE;
        end else begin
            case (state)
                MISS_IDLE: if (start) state <= MISS_REQ;
                MISS_REQ:  if (mem2Dcache_response != '0) state <= MISS_WAIT;
                MISS_WAIT: if (fill_en) state <= MISS_IDLE;
                default:   state <= MISS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == MISS_IDLE && start) addr_q <= block_addr;
        if (state == MISS_REQ) tag_q <= mem2Dcache_response;  // Only kept once accepted
    end

    assign busy = (state != MISS_IDLE);

    // Request held steady under back-pressure
    assign Dcache2mem_command = (state == MISS_REQ) ? BUS_LOAD : BUS_NONE;
    assign Dcache2mem_addr    = (state == MISS_REQ)
                              ? {{(XLEN - ADDR_BITS){1'b0}}, addr_q, {OFFSET_BITS{1'b0}}}
                              : '0;

    // Recorded tag is nonzero so a match is a real response
    assign fill_en    = (state == MISS_WAIT) && (mem2Dcache_tag == tag_q);
    assign fill_addr  = addr_q;
    assign fill_block = mem2Dcache_data;

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the dcache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module dcache_tb \
    -f dcache.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- victim_cache.sv
`timescale 1ns/1ns

module victim_cache #(
    parameter int VICTIM_ENTRIES = 2,
    localparam int ENTRY_BITS = $clog2(VICTIM_ENTRIES)
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [cache_pkg::BLOCK_ADDR_BITS-1:0] lookup_addr,
    output logic                                 hit,
    output cache_pkg::cache_block_t              hit_block,
    input  logic                                 remove_en,
    input  logic                                 insert_en,
    input  logic [cache_pkg::BLOCK_ADDR_BITS-1:0] insert_addr,
    input  cache_pkg::cache_block_t              insert_block
);
    import cache_pkg::*;

    logic [BLOCK_ADDR_BITS-1:0] entry_addr  [VICTIM_ENTRIES];
    cache_block_t               entry_block [VICTIM_ENTRIES];
    logic [VICTIM_ENTRIES-1:0]  entry_valid;

    logic [ENTRY_BITS-1:0] fifo_ptr;    // Oldest entry
    logic [ENTRY_BITS-1:0] hit_idx;
    logic [ENTRY_BITS-1:0] free_idx;
    logic [ENTRY_BITS-1:0] insert_idx;
    logic                  any_free;
    logic                  removing;

    // Fully associative lookup and lowest free entry
    always_comb begin
        hit      = 1'b0;
        hit_idx  = '0;
        any_free = 1'b0;
        free_idx = '0;
        for (int i = VICTIM_ENTRIES - 1; i >= 0; i--) begin
            if (entry_valid[i] && entry_addr[i] == lookup_addr) begin
                hit     = 1'b1;
                hit_idx = ENTRY_BITS'(i);
            end
            if (!entry_valid[i]) begin
                any_free = 1'b1;
                free_idx = ENTRY_BITS'(i);
            end
        end
    end

    assign hit_block = entry_block[hit_idx];
    assign removing  = remove_en && hit;

    // Freed slot first, then an empty one, then the oldest
    assign insert_idx = removing ? hit_idx : (any_free ? free_idx : fifo_ptr);

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            fifo_ptr    <= '0;
        end else begin
            if (removing) begin
                entry_valid[hit_idx] <= 1'b0;
            end
            if (insert_en) begin
                entry_valid[insert_idx] <= 1'b1;  // Wins over the removal above
            end
            if (insert_en && !removing && !any_free) begin  // Oldest overwritten
                fifo_ptr <= (fifo_ptr == ENTRY_BITS'(VICTIM_ENTRIES - 1)) ? '0
                                                                          : fifo_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (insert_en) begin
            entry_addr[insert_idx]  <= insert_addr;
            entry_block[insert_idx] <= insert_block;
        end
    end

endmodule
